/* tb.f */
+incdir+source
source/flash_pkg.sv
source/spi_byte_shifter.sv
source/read_word_packer.sv
source/flash_read_ctrl.sv
source/flash_read_bridge.sv
verif/spi_flash_model.sv
verif/tb_flash_read_bridge.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the flash read bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f tb.f \
    --top-module tb_flash_read_bridge -Mdir "$BUILD" -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* verif/tb_flash_read_bridge.sv */
// ############################
// flash read bridge testbench
// table driven word reads against the serial flash model
// ############################

`timescale 1ns/1ps

`include "flash_config.svh"

module tb_flash_read_bridge;

    localparam int NUM_ROWS = 12;
    localparam int NUM_FIXED = 6;
    localparam int BYTE_CYCLES = 16 * `FLASH_SCK_HALF;
    // 40 bytes of serial time per row covers long read_en holds
    localparam int ROW_BUDGET = 40 * BYTE_CYCLES + 200;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * ROW_BUDGET + 50;

    // one table row where abort rows reset the bridge mid read
    typedef struct packed {
        logic [`FLASH_WORD_ADDR_W-1:0] index;
        logic [9:0]                    hold;
        logic                          second_edge;
        logic                          abort;
    } stim_row_t;

    logic clk = 1'b0;
    logic reset;
    logic read_en;
    logic [`FLASH_WORD_ADDR_W-1:0] read_address;
    logic [31:0] read_data;
    logic read_ready;
    logic flash_sck;
    logic flash_csn;
    logic flash_mosi;
    logic flash_miso;
    int select_count;
    logic [23:0] last_addr;

    stim_row_t stim_table [NUM_ROWS];
    int error_count;
    int check_count;
    int cycle_count = 0;

    flash_read_bridge dut0 (
        .clk          (clk),
        .reset        (reset),
        .read_en      (read_en),
        .read_address (read_address),
        .read_data    (read_data),
        .read_ready   (read_ready),
        .flash_sck    (flash_sck),
        .flash_csn    (flash_csn),
        .flash_mosi   (flash_mosi),
        .flash_miso   (flash_miso)
    );

    spi_flash_model flash0 (
        .flash_sck    (flash_sck),
        .flash_csn    (flash_csn),
        .flash_mosi   (flash_mosi),
        .flash_miso   (flash_miso),
        .select_count (select_count),
        .last_addr    (last_addr)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // run limit so a stuck bridge still ends
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: reads did not finish within %0d clk cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // flash content is the xor of the address bytes with 0x5a
    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
    endfunction

    // user base plus four bytes per word
    function automatic logic [23:0] word_base(input logic [`FLASH_WORD_ADDR_W-1:0] index);
        return `FLASH_USER_BASE + 24'(index) * 24'd4;
    endfunction

    // little endian word with the first flash byte in bits 7:0
    function automatic logic [31:0] expected_word(input logic [`FLASH_WORD_ADDR_W-1:0] index);
        logic [23:0] b;
        b = word_base(index);
        return {flash_byte(b + 24'd3), flash_byte(b + 24'd2),
                flash_byte(b + 24'd1), flash_byte(b)};
    endfunction

    function automatic stim_row_t make_row(input logic [`FLASH_WORD_ADDR_W-1:0] index,
                                           input logic [9:0] hold,
                                           input logic second_edge,
                                           input logic abort);
        stim_row_t row;
        row.index = index;
        row.hold = hold;
        row.second_edge = second_edge;
        row.abort = abort;
        return row;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %0d ns: %s got 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    // one full read that starts and returns on a falling clk edge
    task automatic run_read(input stim_row_t row);
        int cyc;
        int ready_count;
        int falls_before;
        int release_cyc;
        logic [31:0] prev_word;
        logic [31:0] exp_word;
        falls_before = select_count;
        prev_word = read_data;
        exp_word = expected_word(row.index);
        release_cyc = row.second_edge ? int'(row.hold) + 8 : int'(row.hold);
        ready_count = 0;
        cyc = 0;
        read_address = row.index;
        read_en = 1'b1;
        // until the word is in and read_en has been low a few cycles
        while (ready_count == 0 || cyc < release_cyc + 4) begin
            @(negedge clk);
            cyc++;
            if (read_ready) begin
                ready_count++;
                check_value("read_data", read_data, exp_word);
            end else if (ready_count == 0) begin
                // old word stays up while the read runs
                check_value("read_data held", read_data, prev_word);
            end
            if (cyc == int'(row.hold)) begin
                read_en = 1'b0;
            end
            // extra rising edge while busy
            if (row.second_edge && cyc == int'(row.hold) + 4) begin
                read_en = 1'b1;
            end
            if (row.second_edge && cyc == release_cyc) begin
                read_en = 1'b0;
            end
        end
        check_value("read_ready pulses", 32'(ready_count), 32'd1);
        check_value("csn falls", 32'(select_count - falls_before), 32'd1);
        check_value("flash address", 32'(last_addr), 32'(word_base(row.index)));
        // idle pins between reads
        check_value("flash_csn", 32'(flash_csn), 32'd1);
        check_value("flash_sck", 32'(flash_sck), 32'd0);
    endtask

    // start a read and reset the bridge row.hold cycles into it
    task automatic abort_read(input stim_row_t row);
        int cyc;
        logic [31:0] prev_word;
        prev_word = read_data;
        read_address = row.index;
        read_en = 1'b1;
        while (flash_csn) begin
            @(negedge clk);
        end
        for (cyc = 0; cyc < int'(row.hold); cyc++) begin
            @(negedge clk);
            check_value("read_ready", 32'(read_ready), 32'd0);
        end
        reset = 1'b1;
        read_en = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_value("flash_csn", 32'(flash_csn), 32'd1);
        check_value("flash_sck", 32'(flash_sck), 32'd0);
        // nothing may come back for a full read worth of cycles
        for (cyc = 0; cyc < 10 * BYTE_CYCLES; cyc++) begin
            @(negedge clk);
            check_value("read_ready", 32'(read_ready), 32'd0);
            check_value("flash_csn", 32'(flash_csn), 32'd1);
            check_value("read_data held", read_data, prev_word);
        end
    endtask

    initial begin
        logic [9:0] hold;
        void'($urandom(47));
        error_count = 0;
        check_count = 0;
        reset = 1'b1;
        read_en = 1'b0;
        read_address = '0;

        // corner indices, long hold, busy edges and a mid read reset
        stim_table[0] = make_row(18'h00000, 10'd1, 1'b0, 1'b0);
        stim_table[1] = make_row(18'h00001, 10'd400, 1'b0, 1'b0);
        stim_table[2] = make_row(18'h3ffff, 10'd3, 1'b1, 1'b0);
        stim_table[3] = make_row(18'h2aaaa, 10'd150, 1'b0, 1'b1);
        stim_table[4] = make_row(18'h15555, 10'd20, 1'b0, 1'b0);
        stim_table[5] = make_row(18'h00100, 10'd6, 1'b1, 1'b0);
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            hold = 10'(1 + ($urandom % 400));
            // busy edge only fits while the read is still running
            stim_table[i] = make_row(18'($urandom), hold,
                                     (hold < 10'd200) ? 1'($urandom) : 1'b0, 1'b0);
        end

        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_value("flash_csn", 32'(flash_csn), 32'd1);
        check_value("flash_sck", 32'(flash_sck), 32'd0);
        check_value("read_ready", 32'(read_ready), 32'd0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (stim_table[i].abort) begin
                abort_read(stim_table[i]);
            end else begin
                run_read(stim_table[i]);
            end
        end

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verif/spi_flash_model.sv */
// ############################
// serial flash model
// answers command 0x03 in spi mode 0, data is a fixed function of the address
// ############################

`timescale 1ns/1ps

`include "flash_config.svh"

module spi_flash_model (
    input  logic        flash_sck,
    input  logic        flash_csn,
    input  logic        flash_mosi,
    output logic        flash_miso,
    output int          select_count,
    output logic [23:0] last_addr
);

    // chip select falls seen so far
    int falls = 0;
    // receive side, command and address bits
    int rx_select = -1;
    int bit_cnt = 0;
    logic [31:0] in_sr = 32'h0;
    logic reading = 1'b0;
    // transmit side, data bytes
    int tx_select = -1;
    int out_bit = 0;
    logic [23:0] out_addr = 24'h0;
    logic [7:0] out_sr = 8'h00;
    logic miso_r = 1'b0;

    assign flash_miso = miso_r;
    assign select_count = falls;

    // byte stored at flash address a
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
    endfunction

    always @(negedge flash_csn) begin
        falls = falls + 1;
    end

    // mosi is sampled on the rising serial edge
    always @(posedge flash_sck) begin
        if (!flash_csn) begin
            // first edge of a new select starts a fresh transaction
            if (rx_select != falls) begin
                rx_select = falls;
                bit_cnt = 0;
                reading = 1'b0;
            end
            in_sr = {in_sr[30:0], flash_mosi};
            bit_cnt = bit_cnt + 1;
            // command byte then 24 address bits, msb first
            if (bit_cnt == 32 && in_sr[31:24] == `FLASH_READ_CMD) begin
                last_addr = in_sr[23:0];
                reading = 1'b1;
            end
        end
    end

    // miso changes on the falling edge, starting with the last address fall
    always @(negedge flash_sck) begin
        if (!flash_csn && reading) begin
            if (tx_select != falls) begin
                tx_select = falls;
                out_bit = 0;
                out_addr = last_addr;
            end
            if (out_bit == 0) begin
                out_sr = byte_at(out_addr);
                out_addr = out_addr + 24'd1;
            end
            miso_r = out_sr[7];
            out_sr = {out_sr[6:0], 1'b0};
            out_bit = (out_bit + 1) % 8;
        end
    end

endmodule

/* source/flash_read_bridge.sv */
// ############################
// flash read bridge top
// cpu word reads from spi nor flash, stalls cpu until ready
// ############################

`timescale 1ns/1ps

`include "flash_config.svh"

module flash_read_bridge
    import flash_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,

    // cpu side
    input  logic                          read_en,
    input  logic [`FLASH_WORD_ADDR_W-1:0] read_address,
    output logic [31:0]                   read_data,
    output logic                          read_ready,

    // flash pins
    output logic                          flash_sck,
    output logic                          flash_csn,
    output logic                          flash_mosi,
    input  logic                          flash_miso
);

    shift_cmd_t shift_cmd;
    shift_rsp_t shift_rsp;
    logic load_addr;
    logic capture;
    logic [`FLASH_ADDR_W-1:0] latched_addr;

    // sequencing and chip select
    flash_read_ctrl ctrl0 (
        .clk          (clk),
        .reset        (reset),
        .read_en      (read_en),
        .rsp          (shift_rsp),
        .latched_addr (latched_addr),
        .load_addr    (load_addr),
        .capture      (capture),
        .cmd          (shift_cmd),
        .flash_csn    (flash_csn),
        .read_ready   (read_ready)
    );

    // serial clock and data pins
    spi_byte_shifter shifter0 (
        .clk        (clk),
        .reset      (reset),
        .cmd        (shift_cmd),
        .flash_miso (flash_miso),
        .rsp        (shift_rsp),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi)
    );

    // address offset and word assembly
    read_word_packer packer0 (
        .clk          (clk),
        .reset        (reset),
        .load_addr    (load_addr),
        .read_address (read_address),
        .capture      (capture),
        .rsp          (shift_rsp),
        .latched_addr (latched_addr),
        .read_data    (read_data)
    );

endmodule

/* source/flash_read_ctrl.sv */
// ############################
// flash read sequencer
// catches the cpu read edge, runs cmd / addr / data bytes
// drives chip select and releases the cpu with read_ready
// ############################

`timescale 1ns/1ps

`include "flash_config.svh"

module flash_read_ctrl
    import flash_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     read_en,
    input  shift_rsp_t               rsp,
    input  logic [`FLASH_ADDR_W-1:0] latched_addr,
    output logic                     load_addr,
    output logic                     capture,
    output shift_cmd_t               cmd,
    output logic                     flash_csn,
    output logic                     read_ready
);

    read_phase_t phase;

    // cpu strobe registered then delayed for the edge detect
    logic read_en_r;
    logic read_en_d;
    logic request;

    // first byte goes out one cycle after csn falls
    logic kick;
    logic [1:0] byte_cnt;
    logic start_r;
    logic [7:0] tx_r;

    // rising edge only counts when idle so edges during a read are dropped
    assign request = read_en_r && !read_en_d && (phase == IDLE);
    assign load_addr = request;

    // every byte finished during DATA lands in the packer
    assign capture = rsp.done && (phase == DATA);

    assign cmd.start = start_r;
    assign cmd.tx_byte = tx_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            read_en_r <= 1'b0;
            read_en_d <= 1'b0;
            phase <= IDLE;
            kick <= 1'b0;
            byte_cnt <= 2'd0;
            start_r <= 1'b0;
            tx_r <= 8'h00;
            flash_csn <= 1'b1;
            read_ready <= 1'b0;
        end else begin
            read_en_r <= read_en;
            read_en_d <= read_en_r;
            // single cycle pulses default low
            start_r <= 1'b0;
            kick <= 1'b0;
            read_ready <= 1'b0;

            case (phase)
                IDLE: begin
                    if (request) begin
                        phase <= CMD;
                        flash_csn <= 1'b0;
                        kick <= 1'b1;
                        byte_cnt <= 2'd0;
                    end
                end
                CMD: begin
                    if (kick) begin
                        start_r <= 1'b1;
                        tx_r <= `FLASH_READ_CMD;
                    end
                    // address goes msb first
                    if (rsp.done) begin
                        phase <= ADDR;
                        start_r <= 1'b1;
                        tx_r <= latched_addr[23:16];
                    end
                end
                ADDR: begin
                    if (rsp.done) begin
                        start_r <= 1'b1;
                        if (byte_cnt == 2'd2) begin
                            // dummy tx bytes clock the data out
                            phase <= DATA;
                            byte_cnt <= 2'd0;
                            tx_r <= 8'h00;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                            tx_r <= (byte_cnt == 2'd0) ? latched_addr[15:8] : latched_addr[7:0];
                        end
                    end
                end
                DATA: begin
                    if (rsp.done) begin
                        if (byte_cnt == 2'd3) begin
                            // deselect and release the cpu as the word lands
                            phase <= DONE;
                            flash_csn <= 1'b1;
                            read_ready <= 1'b1;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                            start_r <= 1'b1;
                            tx_r <= 8'h00;
                        end
                    end
                end
                DONE: begin
                    // read_ready and the new word are up for this one cycle
                    phase <= IDLE;
                end
                default: phase <= IDLE;
            endcase
        end
    end

    // cpu is released once per read
    ready_single_pulse: assert property (
        @(posedge clk) disable iff (reset) read_ready |=> !read_ready
    ) else $error("read_ready held for more than one cycle");

    // shifter must never run a byte with the flash deselected
    start_needs_select: assert property (
        @(posedge clk) disable iff (reset) cmd.start |-> !flash_csn
    ) else $error("byte started with flash_csn high");

endmodule

/* source/read_word_packer.sv */
// ############################
// read word packer
// latches the flash byte address, packs data bytes little endian
// ############################

`timescale 1ns/1ps

`include "flash_config.svh"

module read_word_packer
    import flash_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load_addr,
    input  logic [`FLASH_WORD_ADDR_W-1:0] read_address,
    input  logic                          capture,
    input  shift_rsp_t                    rsp,
    output logic [`FLASH_ADDR_W-1:0]      latched_addr,
    output logic [31:0]                   read_data
);

    localparam int PAD_W = `FLASH_ADDR_W - `FLASH_WORD_ADDR_W - 2;

    logic [1:0] lane;
    // lanes 0..2 wait here until lane 3 arrives
    logic [23:0] low_bytes;
    // word index times four
    logic [`FLASH_ADDR_W-1:0] byte_offset;

    assign byte_offset = {{PAD_W{1'b0}}, read_address, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            lane <= 2'd0;
        end else if (load_addr) begin
            lane <= 2'd0;
        end else if (capture) begin
            lane <= lane + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_addr) begin
            latched_addr <= `FLASH_USER_BASE + byte_offset;
        end
        if (capture) begin
            case (lane)
                2'd0: low_bytes[7:0] <= rsp.rx_byte;
                2'd1: low_bytes[15:8] <= rsp.rx_byte;
                2'd2: low_bytes[23:16] <= rsp.rx_byte;
                // whole word at once, old value stays up during the read
                default: read_data <= {rsp.rx_byte, low_bytes};
            endcase
        end
    end

endmodule

/* source/spi_byte_shifter.sv */
// ############################
// spi byte shifter, mode 0
// divides clk into flash_sck and moves one byte each way
// ############################

`timescale 1ns/1ps

`include "flash_config.svh"

module spi_byte_shifter
    import flash_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  shift_cmd_t cmd,
    input  logic       flash_miso,
    output shift_rsp_t rsp,
    output logic       flash_sck,
    output logic       flash_mosi
);

    localparam int HALF = `FLASH_SCK_HALF;
    localparam int DIV_W = (HALF > 1) ? $clog2(HALF) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(HALF - 1);
    // start cycle counts as the first divider tick
    // so a byte takes exactly 16 half periods from start to done
    localparam logic [DIV_W-1:0] DIV_FIRST = DIV_W'(1 % HALF);

    logic active;
    logic [DIV_W-1:0] div_cnt;
    logic tick;
    // falling edges seen in this byte
    logic [2:0] fall_cnt;
    logic [7:0] tx_sr;
    logic [7:0] rx_sr;
    logic sck_r;
    logic done_r;

    // half period boundary, sck toggles here
    assign tick = active && (div_cnt == DIV_LAST);

    assign flash_sck = sck_r;
    // msb first, tx_sr drains to zero so mosi idles low
    assign flash_mosi = tx_sr[7];
    assign rsp.done = done_r;
    assign rsp.rx_byte = rx_sr;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            div_cnt <= '0;
            fall_cnt <= 3'd0;
            tx_sr <= 8'h00;
            sck_r <= 1'b0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (cmd.start && !active) begin
                active <= 1'b1;
                div_cnt <= DIV_FIRST;
                fall_cnt <= 3'd0;
                tx_sr <= cmd.tx_byte;
            end else if (active) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    sck_r <= !sck_r;
                    // falling edge, next bit onto mosi
                    if (sck_r) begin
                        tx_sr <= {tx_sr[6:0], 1'b0};
                        fall_cnt <= fall_cnt + 3'd1;
                        // eighth fall, sck is back low
                        if (fall_cnt == 3'd7) begin
                            active <= 1'b0;
                            done_r <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // sample on the rising edge, miso was set up on the previous fall
    always_ff @(posedge clk) begin
        if (tick && !sck_r) begin
            rx_sr <= {rx_sr[6:0], flash_miso};
        end
    end

    // sequencer waits for done before the next start
    no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset) cmd.start |-> !active
    ) else $error("byte start while shifter busy");

endmodule

/* source/flash_pkg.sv */
// ############################
// flash read bridge types
// read sequencer states and the byte shifter request/response
// ############################

package flash_pkg;

    // phases of one read transaction
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DATA,
        DONE
    } read_phase_t;

    // request to the byte shifter
    // start is a single cycle pulse, only honoured while the shifter is idle
    typedef struct packed {
        logic       start;
        logic [7:0] tx_byte;
    } shift_cmd_t;

    // response from the byte shifter
    // rx_byte is valid in the done cycle and held until the next byte
    typedef struct packed {
        logic       done;
        logic [7:0] rx_byte;
    } shift_rsp_t;

endpackage

/* source/flash_config.svh */
// ############################
// flash read bridge config
// user region offset, address widths, serial clock divider, command byte
// ############################

`ifndef FLASH_CONFIG_SVH
`define FLASH_CONFIG_SVH

// user data starts 1 MiB into the flash, below that is the bitstream
`define FLASH_USER_BASE 24'h100000

// cpu word index width and flash byte address width
`define FLASH_WORD_ADDR_W 18
`define FLASH_ADDR_W 24

// clk cycles per half period of flash_sck
`define FLASH_SCK_HALF 2

// standard serial read, no dummy cycles
`define FLASH_READ_CMD 8'h03

`endif
